// File: verilog/board_pkg.sv
//////////////////////////////////////////////////
// Board constants and the GPIO event record
// RtcDivide assumes a 20 MHz soc_clk for a ~32 kHz tick
// Record fields are sized for GpioCount up to 4
//////////////////////////////////////////////////

package board_pkg;

  // Board inputs
  localparam int unsigned GpioCount = 4;

  // RTC tick every RtcDivide+1 cycles
  localparam int unsigned RtcDivide   = 610;
  localparam int unsigned RtcCntWidth = $clog2(RtcDivide + 1);

  // Event buffer
  localparam int unsigned FifoDepth    = 4;
  localparam int unsigned FifoPtrWidth = $clog2(FifoDepth);
  localparam int unsigned FifoCntWidth = $clog2(FifoDepth + 1);

  // UART, two 8N1 bytes per record
  localparam int unsigned BaudDiv       = 16;
  localparam int unsigned BaudCntWidth  = $clog2(BaudDiv);
  localparam int unsigned FrameBits     = 20;
  localparam int unsigned FrameCntWidth = $clog2(FrameBits);

  localparam int unsigned SeqWidth = 8;

  typedef struct packed {
    logic [SeqWidth-1:0]  seq;
    logic [GpioCount-1:0] change;
    logic [GpioCount-1:0] level;
  } gpio_event_t;

endpackage

// File: verilog/wb_pkg.sv
//////////////////////////////////////////////////
// Wishbone classic word definitions
// Single slave, so no address or select lines
// Data width must equal the event record width
//////////////////////////////////////////////////

package wb_pkg;

  localparam int unsigned WbDataWidth = 16;

  // Bus data word, shared by master and slave ports
  typedef logic [WbDataWidth-1:0] wb_word_t;

endpackage

// File: verilog/board_io.sv
//////////////////////////////////////////////////
// Board-side input conditioning
// Reset asserts at once, releases 2 cycles late
// Switch inputs are assumed free of bounce
//////////////////////////////////////////////////

`timescale 1ns/1ps

module board_io import board_pkg::*; (
  input  logic                 soc_clk,
  input  logic                 rst_n,
  input  logic [GpioCount-1:0] gpio_i,
  input  logic                 fetch_en_i,
  output logic                 rst_sync_n_o,
  output logic                 rtc_tick_o,
  output logic [GpioCount-1:0] gpio_o,
  output logic                 fetch_en_o
);

  //////////////////////////////////////////////////
  // Reset synchronizer
  //////////////////////////////////////////////////

  logic [1:0] rst_sync_q;

  always_ff @(posedge soc_clk, negedge rst_n) begin
    if (!rst_n) begin
      rst_sync_q <= 2'b00;
    end else begin
      rst_sync_q <= {rst_sync_q[0], 1'b1};
    end
  end

  assign rst_sync_n_o = rst_sync_q[1];

  //////////////////////////////////////////////////
  // RTC tick divider
  //////////////////////////////////////////////////

  logic [RtcCntWidth-1:0] rtc_cnt_q;

  always_ff @(posedge soc_clk, negedge rst_sync_n_o) begin
    if (!rst_sync_n_o) begin
      rtc_cnt_q <= '0;
    end else if (rtc_tick_o) begin
      rtc_cnt_q <= '0;
    end else begin
      rtc_cnt_q <= rtc_cnt_q + 1'b1;
    end
  end

  assign rtc_tick_o = (rtc_cnt_q == RtcCntWidth'(RtcDivide));

  //////////////////////////////////////////////////
  // Input synchronizers
  //////////////////////////////////////////////////

  logic [GpioCount-1:0] gpio_meta_q, gpio_sync_q;
  logic                 fetch_meta_q, fetch_sync_q;

  always_ff @(posedge soc_clk, negedge rst_sync_n_o) begin
    if (!rst_sync_n_o) begin
      gpio_meta_q  <= '0;
      gpio_sync_q  <= '0;
      fetch_meta_q <= 1'b0;
      fetch_sync_q <= 1'b0;
    end else begin
      gpio_meta_q  <= gpio_i;
      gpio_sync_q  <= gpio_meta_q;
      fetch_meta_q <= fetch_en_i;
      fetch_sync_q <= fetch_meta_q;
    end
  end

  assign gpio_o     = gpio_sync_q;
  assign fetch_en_o = fetch_sync_q;

  // Tick is a single-cycle pulse
  a_tick_pulse : assert property (@(posedge soc_clk) disable iff (!rst_sync_n_o)
    rtc_tick_o |=> !rtc_tick_o);

endmodule

// File: verilog/gpio_event_sampler.sv
//////////////////////////////////////////////////
// GPIO change detector, Wishbone write master
// Ticks are ignored while a write waits for ack
// so changes during a stall merge into one record
//////////////////////////////////////////////////

`timescale 1ns/1ps

module gpio_event_sampler import board_pkg::*, wb_pkg::*; (
  input  logic                 soc_clk,
  input  logic                 rst_n,
  input  logic                 rtc_tick_i,
  input  logic                 fetch_en_i,
  input  logic [GpioCount-1:0] gpio_i,
  output logic                 wr_cyc_o,
  output logic                 wr_stb_o,
  output wb_word_t             wr_dat_o,
  input  logic                 wr_ack_i
);

  logic                 cyc_q;
  logic [GpioCount-1:0] last_q;
  logic [SeqWidth-1:0]  seq_q;
  gpio_event_t          rec_q;
  logic                 new_event;

  // Sample only when idle on the bus
  assign new_event = rtc_tick_i & fetch_en_i & (gpio_i != last_q) & ~cyc_q;

  always_ff @(posedge soc_clk, negedge rst_n) begin
    if (!rst_n) begin
      cyc_q  <= 1'b0;
      last_q <= '0;
      seq_q  <= '0;
    end else if (cyc_q) begin
      if (wr_ack_i) begin
        cyc_q  <= 1'b0;
        last_q <= rec_q.level;
        // Wraps from 255 to 0
        seq_q  <= seq_q + 1'b1;
      end
    end else if (new_event) begin
      cyc_q <= 1'b1;
    end
  end

  // Record payload
  always_ff @(posedge soc_clk) begin
    if (new_event) begin
      rec_q.seq    <= seq_q;
      rec_q.change <= gpio_i ^ last_q;
      rec_q.level  <= gpio_i;
    end
  end

  assign wr_cyc_o = cyc_q;
  assign wr_stb_o = cyc_q;
  assign wr_dat_o = rec_q;

  // Request and data held until the slave acks
  a_wr_hold : assert property (@(posedge soc_clk) disable iff (!rst_n)
    wr_stb_o && !wr_ack_i |=> wr_stb_o && $stable(wr_dat_o));

endmodule

// File: verilog/event_fifo.sv
//////////////////////////////////////////////////
// Wishbone-slave FIFO with one write and one read port
// Acks are registered and come one cycle after stb
// A written record is readable one cycle later
//////////////////////////////////////////////////

`timescale 1ns/1ps

module event_fifo import board_pkg::*, wb_pkg::*; #(
  parameter type payload_t = wb_word_t
) (
  input  logic     soc_clk,
  input  logic     rst_n,
  input  logic     wr_cyc_i,
  input  logic     wr_stb_i,
  input  payload_t wr_dat_i,
  output logic     wr_ack_o,
  input  logic     rd_cyc_i,
  input  logic     rd_stb_i,
  output payload_t rd_dat_o,
  output logic     rd_ack_o
);

  payload_t                mem_q [FifoDepth];
  logic [FifoPtrWidth-1:0] wr_ptr_q, rd_ptr_q;
  logic [FifoCntWidth-1:0] count_q;
  logic                    wr_ack_q, rd_ack_q;
  logic                    full, empty;
  logic                    do_wr, do_rd;

  assign full  = (count_q == FifoCntWidth'(FifoDepth));
  assign empty = (count_q == '0);

  // No new transfer in the ack cycle while stb is still held
  assign do_wr = wr_cyc_i & wr_stb_i & ~wr_ack_q & ~full;
  assign do_rd = rd_cyc_i & rd_stb_i & ~rd_ack_q & ~empty;

  //////////////////////////////////////////////////
  // Pointers, count and acks
  //////////////////////////////////////////////////

  always_ff @(posedge soc_clk, negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      wr_ack_q <= 1'b0;
      rd_ack_q <= 1'b0;
    end else begin
      wr_ack_q <= do_wr;
      rd_ack_q <= do_rd;
      if (do_wr) begin
        wr_ptr_q <= (wr_ptr_q == FifoPtrWidth'(FifoDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_rd) begin
        rd_ptr_q <= (rd_ptr_q == FifoPtrWidth'(FifoDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_wr && !do_rd) begin
        count_q <= count_q + 1'b1;
      end else if (do_rd && !do_wr) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Storage and read data
  always_ff @(posedge soc_clk) begin
    if (do_wr) begin
      mem_q[wr_ptr_q] <= wr_dat_i;
    end
    if (do_rd) begin
      rd_dat_o <= mem_q[rd_ptr_q];
    end
  end

  assign wr_ack_o = wr_ack_q;
  assign rd_ack_o = rd_ack_q;

  // Occupancy stays in range after every acked transfer
  a_no_ack_full : assert property (@(posedge soc_clk) disable iff (!rst_n)
    wr_ack_o |-> count_q != '0 && count_q <= FifoCntWidth'(FifoDepth));
  a_no_ack_empty : assert property (@(posedge soc_clk) disable iff (!rst_n)
    rd_ack_o |-> count_q < FifoCntWidth'(FifoDepth));

endmodule

// File: verilog/event_uart_tx.sv
//////////////////////////////////////////////////
// Wishbone read master and UART transmitter
// Each record goes out as two 8N1 bytes, LSB first
// Next read only after the second stop bit
//////////////////////////////////////////////////

`timescale 1ns/1ps

module event_uart_tx import board_pkg::*, wb_pkg::*; (
  input  logic     soc_clk,
  input  logic     rst_n,
  output logic     rd_cyc_o,
  output logic     rd_stb_o,
  input  wb_word_t rd_dat_i,
  input  logic     rd_ack_i,
  output logic     uart_tx_o
);

  typedef enum logic [1:0] {
    StIdle,
    StReq,
    StShift
  } state_e;

  state_e                   state_q;
  logic [BaudCntWidth-1:0]  baud_q;
  logic [FrameCntWidth-1:0] bit_q;
  logic [FrameBits-1:0]     frame_q;
  gpio_event_t              rec;
  logic                     bit_end;

  assign rec     = rd_dat_i;
  assign bit_end = (baud_q == BaudCntWidth'(BaudDiv - 1));

  //////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////

  always_ff @(posedge soc_clk, negedge rst_n) begin
    if (!rst_n) begin
      state_q <= StIdle;
      baud_q  <= '0;
      bit_q   <= '0;
    end else begin
      case (state_q)
        StIdle: state_q <= StReq;
        StReq: begin
          if (rd_ack_i) begin
            state_q <= StShift;
            baud_q  <= '0;
            bit_q   <= '0;
          end
        end
        StShift: begin
          baud_q <= bit_end ? '0 : baud_q + 1'b1;
          if (bit_end) begin
            bit_q <= bit_q + 1'b1;
            // Last stop bit done
            if (bit_q == FrameCntWidth'(FrameBits - 1)) begin
              state_q <= StIdle;
            end
          end
        end
        default: state_q <= StIdle;
      endcase
    end
  end

  // Frame, bit 0 leaves first
  always_ff @(posedge soc_clk) begin
    if (state_q == StReq && rd_ack_i) begin
      frame_q <= {1'b1, rec.change, rec.level, 1'b0, 1'b1, rec.seq, 1'b0};
    end else if (state_q == StShift && bit_end) begin
      frame_q <= {1'b1, frame_q[FrameBits-1:1]};
    end
  end

  assign rd_cyc_o  = (state_q == StReq);
  assign rd_stb_o  = (state_q == StReq);
  assign uart_tx_o = (state_q == StShift) ? frame_q[0] : 1'b1;

endmodule

// File: verilog/croc_event_top.sv
//////////////////////////////////////////////////
// Event tracer top level
// Raw rst_n and switch inputs may be asynchronous
//////////////////////////////////////////////////

`timescale 1ns/1ps

module croc_event_top import board_pkg::*, wb_pkg::*; (
  input  logic                 soc_clk,
  input  logic                 rst_n,
  input  logic                 fetch_en_i,
  input  logic [GpioCount-1:0] gpio_i,
  output logic                 uart_tx_o
);

  logic                 rst_sync_n, rtc_tick, fetch_en_sync;
  logic [GpioCount-1:0] gpio_sync;
  logic                 wr_cyc, wr_stb, wr_ack;
  logic                 rd_cyc, rd_stb, rd_ack;
  wb_word_t             wr_dat;
  gpio_event_t          rd_dat;

  board_io i_board_io (
    .soc_clk      ( soc_clk       ),
    .rst_n        ( rst_n         ),
    .gpio_i       ( gpio_i        ),
    .fetch_en_i   ( fetch_en_i    ),
    .rst_sync_n_o ( rst_sync_n    ),
    .rtc_tick_o   ( rtc_tick      ),
    .gpio_o       ( gpio_sync     ),
    .fetch_en_o   ( fetch_en_sync )
  );

  gpio_event_sampler i_sampler (
    .soc_clk    ( soc_clk       ),
    .rst_n      ( rst_sync_n    ),
    .rtc_tick_i ( rtc_tick      ),
    .fetch_en_i ( fetch_en_sync ),
    .gpio_i     ( gpio_sync     ),
    .wr_cyc_o   ( wr_cyc        ),
    .wr_stb_o   ( wr_stb        ),
    .wr_dat_o   ( wr_dat        ),
    .wr_ack_i   ( wr_ack        )
  );

  event_fifo #(
    .payload_t ( gpio_event_t )
  ) i_fifo (
    .soc_clk  ( soc_clk    ),
    .rst_n    ( rst_sync_n ),
    .wr_cyc_i ( wr_cyc     ),
    .wr_stb_i ( wr_stb     ),
    .wr_dat_i ( wr_dat     ),
    .wr_ack_o ( wr_ack     ),
    .rd_cyc_i ( rd_cyc     ),
    .rd_stb_i ( rd_stb     ),
    .rd_dat_o ( rd_dat     ),
    .rd_ack_o ( rd_ack     )
  );

  event_uart_tx i_uart_tx (
    .soc_clk   ( soc_clk    ),
    .rst_n     ( rst_sync_n ),
    .rd_cyc_o  ( rd_cyc     ),
    .rd_stb_o  ( rd_stb     ),
    .rd_dat_i  ( rd_dat     ),
    .rd_ack_i  ( rd_ack     ),
    .uart_tx_o ( uart_tx_o  )
  );

endmodule

// File: tb/tb_clkgen.sv
//////////////////////////////////////////////////
// Testbench clock and power-on reset
// 40 ns soc_clk, reset low for the first 4 cycles
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_clkgen (
  output logic soc_clk,
  output logic rst_n
);

  localparam int unsigned HalfPeriod  = 20;
  localparam int unsigned ResetCycles = 4;
  localparam int unsigned DriveDelay  = 2;

  initial begin
    soc_clk = 1'b0;
    forever #(HalfPeriod) soc_clk = ~soc_clk;
  end

  // Release just after an edge, like the other inputs
  initial begin
    rst_n = 1'b0;
    repeat (ResetCycles) @(posedge soc_clk);
    #(DriveDelay);
    rst_n = 1'b1;
  end

endmodule

// File: tb/tb_event_top.sv
//////////////////////////////////////////////////
// Event tracer testbench
// Expected records come from the GPIO levels driven
// Each level is held for at least one full tick
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_event_top import board_pkg::*; ();

  localparam int unsigned DriveDelay   = 2;
  localparam int unsigned TickCycles   = RtcDivide + 1;
  localparam int unsigned WaitLimit    = 3 * TickCycles;
  localparam int unsigned RandomLevels = 20;

  logic                 soc_clk, por_n, rst_n, uart_tx;
  logic                 run_rst_n = 1'b1;
  logic                 fetch_en  = 1'b0;
  logic [GpioCount-1:0] gpio      = '0;

  gpio_event_t          exp_q[$];
  gpio_event_t          rx_q[$];
  logic [GpioCount-1:0] last_level    = '0;
  logic [SeqWidth-1:0]  next_seq      = '0;
  int unsigned          starts_seen   = 0;
  int unsigned          pushed_count  = 0;
  int unsigned          checked_count = 0;

  assign rst_n = por_n & run_rst_n;

  tb_clkgen i_clkgen (
    .soc_clk ( soc_clk ),
    .rst_n   ( por_n   )
  );

  croc_event_top dut0 (
    .soc_clk    ( soc_clk  ),
    .rst_n      ( rst_n    ),
    .fetch_en_i ( fetch_en ),
    .gpio_i     ( gpio     ),
    .uart_tx_o  ( uart_tx  )
  );

  //////////////////////////////////////////////////
  // Reference model and checks
  //////////////////////////////////////////////////

  function automatic gpio_event_t expected_event(input logic [GpioCount-1:0] last,
                                                 input logic [GpioCount-1:0] level,
                                                 input logic [SeqWidth-1:0]  seq);
    gpio_event_t ev;
    ev.seq    = seq;
    ev.change = last ^ level;
    ev.level  = level;
    return ev;
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic check_event(input string name, input gpio_event_t want, input gpio_event_t got);
    if (got !== want) begin
      stop_on_error($sformatf("CHECK FAILED at %0t: %s expected %04h, actual %04h",
                              $time, name, want, got));
    end
  endtask

  task automatic check_line(input string name, input logic want, input logic got);
    if (got !== want) begin
      stop_on_error($sformatf("CHECK FAILED at %0t: %s expected %b, actual %b",
                              $time, name, want, got));
    end
  endtask

  // New record only when the level differs from the last one reported
  task automatic predict_record(input logic [GpioCount-1:0] level);
    if (level != last_level) begin
      exp_q.push_back(expected_event(last_level, level, next_seq));
      last_level = level;
      next_seq++;
      pushed_count++;
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  task automatic set_pins(input logic [GpioCount-1:0] level);
    @(posedge soc_clk);
    #(DriveDelay);
    gpio = level;
  endtask

  task automatic wait_reset_release();
    int unsigned cycles;
    cycles = 0;
    while (!rst_n || cycles < 3) begin
      @(posedge soc_clk);
      cycles++;
      if (cycles > 50) begin
        stop_on_error("Timeout: reset never released");
      end
    end
    #(DriveDelay);
  endtask

  task automatic wait_start_bit(input int unsigned seen_before, input logic [SeqWidth-1:0] seq);
    int unsigned cycles;
    cycles = 0;
    while (starts_seen == seen_before) begin
      @(posedge soc_clk);
      cycles++;
      if (cycles > WaitLimit) begin
        stop_on_error($sformatf("Timeout: record seq %0d never started on uart_tx_o", seq));
      end
    end
  endtask

  task automatic wait_drained();
    int unsigned cycles;
    cycles = 0;
    while (exp_q.size() != 0) begin
      @(posedge soc_clk);
      cycles++;
      if (cycles > WaitLimit) begin
        stop_on_error($sformatf("Timeout: record seq %0d with level %b never arrived",
                                exp_q[0].seq, exp_q[0].level));
      end
    end
  endtask

  //////////////////////////////////////////////////
  // UART monitor, samples each bit at its middle
  //////////////////////////////////////////////////

  initial begin : uart_monitor
    logic [FrameBits-1:0] bits;
    gpio_event_t          rec;
    forever begin
      @(negedge soc_clk);
      if (rst_n && uart_tx === 1'b0) begin
        starts_seen++;
        repeat (BaudDiv / 2) @(negedge soc_clk);
        bits[0] = uart_tx;
        for (int i = 1; i < FrameBits; i++) begin
          repeat (BaudDiv) @(negedge soc_clk);
          bits[i] = uart_tx;
        end
        check_line("uart_tx_o first start bit", 1'b0, bits[0]);
        check_line("uart_tx_o first stop bit", 1'b1, bits[9]);
        check_line("uart_tx_o second start bit", 1'b0, bits[10]);
        check_line("uart_tx_o second stop bit", 1'b1, bits[19]);
        rec.seq                = bits[8:1];
        {rec.change, rec.level} = bits[18:11];
        rx_q.push_back(rec);
      end
    end
  end

  initial begin : compare_records
    gpio_event_t got;
    forever begin
      @(posedge soc_clk);
      while (rx_q.size() != 0) begin
        got = rx_q.pop_front();
        if (exp_q.size() == 0) begin
          stop_on_error($sformatf("Unexpected record %04h on uart_tx_o at %0t", got, $time));
        end
        check_event("uart_tx_o record", exp_q.pop_front(), got);
        checked_count++;
      end
    end
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin : stimulus
    logic [GpioCount-1:0] level;
    int unsigned          seen;
    void'($urandom(99061));
    wait_reset_release();
    check_line("uart_tx_o idle after reset", 1'b1, uart_tx);

    // Fetch disabled, changes must stay silent
    set_pins(4'b1111);
    repeat (TickCycles) @(posedge soc_clk);
    set_pins(4'b0101);
    repeat (TickCycles) @(posedge soc_clk);
    set_pins(4'b0000);
    repeat (TickCycles) @(posedge soc_clk);
    if (starts_seen != 0) begin
      stop_on_error("Bytes appeared on uart_tx_o while fetch enable was low");
    end
    #(DriveDelay);
    check_line("uart_tx_o idle with fetch off", 1'b1, uart_tx);

    @(posedge soc_clk);
    #(DriveDelay);
    fetch_en = 1'b1;
    repeat (TickCycles) @(posedge soc_clk);

    // Single pin, first record
    seen = starts_seen;
    set_pins(4'b0100);
    predict_record(4'b0100);
    wait_start_bit(seen, 8'd0);

    // Start bit is a few cycles after a tick, so these land in one window
    set_pins(4'b0101);
    repeat (3) @(posedge soc_clk);
    set_pins(4'b1101);
    repeat (3) @(posedge soc_clk);
    set_pins(4'b1001);
    predict_record(4'b1001);
    wait_drained();

    // Random levels, every fifth one repeats the previous
    for (int i = 0; i < RandomLevels; i++) begin
      level = (i % 5 == 4) ? last_level : GpioCount'($urandom);
      set_pins(level);
      predict_record(level);
      repeat (2 * TickCycles) @(posedge soc_clk);
    end
    wait_drained();

    // Reset with a nonzero level held
    set_pins(4'b1011);
    predict_record(4'b1011);
    repeat (2 * TickCycles) @(posedge soc_clk);
    wait_drained();
    repeat (BaudDiv) @(posedge soc_clk);
    #(DriveDelay);
    run_rst_n = 1'b0;
    repeat (4) @(posedge soc_clk);
    #(DriveDelay);
    run_rst_n  = 1'b1;
    last_level = '0;
    next_seq   = '0;
    predict_record(4'b1011);
    wait_reset_release();
    check_line("uart_tx_o idle after mid-run reset", 1'b1, uart_tx);
    wait_drained();
    repeat (TickCycles) @(posedge soc_clk);

    if (checked_count == pushed_count && rx_q.size() == 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      stop_on_error($sformatf("Checked %0d records, expected %0d", checked_count, pushed_count));
    end
  end

endmodule

// File: compile.f
verilog/board_pkg.sv
verilog/wb_pkg.sv
verilog/board_io.sv
verilog/gpio_event_sampler.sv
verilog/event_fifo.sv
verilog/event_uart_tx.sv
verilog/croc_event_top.sv
tb/tb_clkgen.sv
tb/tb_event_top.sv

// File: Makefile
TOP := tb_event_top

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --assert --timescale 1ns/1ps -j 0 \
		--top-module $(TOP) -f compile.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir
